// ==== dma_settings.svh ====
// --------------------------------------------------------------------------
// global widths and default queue depth of the TCDM DMA engine
// included by the packages and the top level
// --------------------------------------------------------------------------

`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// byte address into the TCDM
`define DMA_ADDR_W 32

// memory word and control register word
`define DMA_DATA_W 32

// row counter of a 2D job
`define DMA_REPS_W 16

// control port offset width
`define DMA_REG_AW 6

// jobs that can wait behind the one in flight
`define DMA_QUEUE_DEPTH 2

`endif

// ==== dma_reg_pkg.sv ====
// --------------------------------------------------------------------------
// register map and control port types of the DMA frontend
// --------------------------------------------------------------------------

`include "dma_settings.svh"

package dma_reg_pkg;

  // control port address and data
  typedef logic [`DMA_REG_AW-1:0] reg_addr_t;
  typedef logic [`DMA_DATA_W-1:0] reg_data_t;

  // ------------------------------------------------------------------------
  // register offsets
  // ------------------------------------------------------------------------
  // reading REG_NEXT_ID launches the programmed transfer
  typedef enum logic [`DMA_REG_AW-1:0] {
    REG_SRC        = 6'h00,
    REG_DST        = 6'h04,
    REG_LEN        = 6'h08,
    REG_SRC_STRIDE = 6'h0C,
    REG_DST_STRIDE = 6'h10,
    REG_REPS       = 6'h14,
    REG_NEXT_ID    = 6'h18,
    REG_DONE_ID    = 6'h1C,
    REG_STATUS     = 6'h20
  } dma_reg_e;

endpackage

// ==== dma_xfer_pkg.sv ====
// --------------------------------------------------------------------------
// transfer field types and state encodings shared by the datapath modules
// --------------------------------------------------------------------------

`include "dma_settings.svh"

package dma_xfer_pkg;

  // job fields
  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  // bytes per row, multiple of the word size
  typedef logic [`DMA_ADDR_W-1:0] len_t;
  typedef logic [`DMA_ADDR_W-1:0] stride_t;
  // zero rows counts as one row
  typedef logic [`DMA_REPS_W-1:0] reps_t;

  typedef logic [`DMA_DATA_W-1:0] word_t;
  typedef logic [`DMA_DATA_W-1:0] xfer_id_t;

  // ------------------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    MID_IDLE,
    MID_ISSUE,
    MID_WAIT
  } mid_state_e;

  typedef enum logic [1:0] {
    BE_IDLE,
    BE_READ,
    BE_RDATA,
    BE_WRITE
  } be_state_e;

endpackage

// ==== dma_ctrl_regs.sv ====
// --------------------------------------------------------------------------
// DMA frontend: configuration registers, launch and transfer ID counters
// a read of the launch register pushes the programmed job into the queue
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module dma_ctrl_regs
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // peripheral-style control port
  input  logic      cfg_req_i,
  input  reg_addr_t cfg_addr_i,
  input  logic      cfg_we_i,
  input  reg_data_t cfg_wdata_i,
  output logic      cfg_gnt_o,
  output reg_data_t cfg_rdata_o,
  output logic      cfg_rvalid_o,
  // job towards the request queue
  output logic      push_o,
  input  logic      full_i,
  output addr_t     job_src_o,
  output addr_t     job_dst_o,
  output len_t      job_len_o,
  output stride_t   job_src_stride_o,
  output stride_t   job_dst_stride_o,
  output reps_t     job_reps_o,
  // status from the datapath
  input  logic      job_done_i,
  input  logic      busy_i
);

  addr_t     src_q, dst_q;
  len_t      len_q;
  stride_t   src_stride_q, dst_stride_q;
  reps_t     reps_q;
  xfer_id_t  next_id_q, done_id_q;
  logic      launch_rd;
  logic      access;
  reg_data_t rdata_d;

  // only a launch into a full queue has to wait
  assign launch_rd = cfg_req_i && !cfg_we_i && (cfg_addr_i == REG_NEXT_ID);
  assign cfg_gnt_o = !(launch_rd && full_i);
  assign access    = cfg_req_i && cfg_gnt_o;
  assign push_o    = launch_rd && !full_i;

  assign job_src_o        = src_q;
  assign job_dst_o        = dst_q;
  assign job_len_o        = len_q;
  assign job_src_stride_o = src_stride_q;
  assign job_dst_stride_o = dst_stride_q;
  assign job_reps_o       = reps_q;

  // ------------------------------------------------------------------------
  // configuration writes
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (access && cfg_we_i) begin
      case (cfg_addr_i)
        REG_SRC:        src_q        <= cfg_wdata_i;
        REG_DST:        dst_q        <= cfg_wdata_i;
        REG_LEN:        len_q        <= cfg_wdata_i;
        REG_SRC_STRIDE: src_stride_q <= cfg_wdata_i;
        REG_DST_STRIDE: dst_stride_q <= cfg_wdata_i;
        REG_REPS:       reps_q       <= cfg_wdata_i[`DMA_REPS_W-1:0];
        default: ;
      endcase
    end
  end

  // read mux, writes answer with zero
  always_comb begin
    rdata_d = '0;
    if (!cfg_we_i) begin
      case (cfg_addr_i)
        REG_SRC:        rdata_d = src_q;
        REG_DST:        rdata_d = dst_q;
        REG_LEN:        rdata_d = len_q;
        REG_SRC_STRIDE: rdata_d = src_stride_q;
        REG_DST_STRIDE: rdata_d = dst_stride_q;
        REG_REPS:       rdata_d = reg_data_t'(reps_q);
        REG_NEXT_ID:    rdata_d = next_id_q;
        REG_DONE_ID:    rdata_d = done_id_q;
        REG_STATUS:     rdata_d = reg_data_t'(busy_i);
        default:        rdata_d = '0;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // response and ID counters
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (access) begin
      cfg_rdata_o <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_rvalid_o <= 1'b0;
      // first launch hands out ID 1
      next_id_q    <= xfer_id_t'(1);
      done_id_q    <= '0;
    end else begin
      cfg_rvalid_o <= access;
      if (push_o) begin
        next_id_q <= next_id_q + xfer_id_t'(1);
      end
      if (job_done_i) begin
        done_id_q <= done_id_q + xfer_id_t'(1);
      end
    end
  end

endmodule

// ==== dma_req_fifo.sv ====
// --------------------------------------------------------------------------
// queue of pending 2D jobs between the register frontend and the midend
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module dma_req_fifo
  import dma_xfer_pkg::*;
#(
  parameter int unsigned Depth = 2
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // write side
  input  logic    push_i,
  output logic    full_o,
  input  addr_t   src_i,
  input  addr_t   dst_i,
  input  len_t    len_i,
  input  stride_t src_stride_i,
  input  stride_t dst_stride_i,
  input  reps_t   reps_i,
  // read side
  output logic    valid_o,
  input  logic    pop_i,
  output addr_t   src_o,
  output addr_t   dst_o,
  output len_t    len_o,
  output stride_t src_stride_o,
  output stride_t dst_stride_o,
  output reps_t   reps_o,
  output logic    empty_o
);

  // a single entry still needs a one bit pointer
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  addr_t   src_mem [Depth];
  addr_t   dst_mem [Depth];
  len_t    len_mem [Depth];
  stride_t src_stride_mem [Depth];
  stride_t dst_stride_mem [Depth];
  reps_t   reps_mem [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push, do_pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign valid_o = !empty_o;
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  assign src_o        = src_mem[rd_ptr_q];
  assign dst_o        = dst_mem[rd_ptr_q];
  assign len_o        = len_mem[rd_ptr_q];
  assign src_stride_o = src_stride_mem[rd_ptr_q];
  assign dst_stride_o = dst_stride_mem[rd_ptr_q];
  assign reps_o       = reps_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      src_mem[wr_ptr_q]        <= src_i;
      dst_mem[wr_ptr_q]        <= dst_i;
      len_mem[wr_ptr_q]        <= len_i;
      src_stride_mem[wr_ptr_q] <= src_stride_i;
      dst_stride_mem[wr_ptr_q] <= dst_stride_i;
      reps_mem[wr_ptr_q]       <= reps_i;
    end
  end

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + CntW'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

endmodule

// ==== dma_2d_midend.sv ====
// --------------------------------------------------------------------------
// 2D midend: splits a queued job into rows and feeds them to the backend
// pulses job_done_o once the last row has been copied
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module dma_2d_midend
  import dma_xfer_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // job from the queue
  input  logic    valid_i,
  output logic    pop_o,
  input  addr_t   job_src_i,
  input  addr_t   job_dst_i,
  input  len_t    job_len_i,
  input  stride_t job_src_stride_i,
  input  stride_t job_dst_stride_i,
  input  reps_t   job_reps_i,
  // rows towards the backend
  output logic    row_start_o,
  output addr_t   row_src_o,
  output addr_t   row_dst_o,
  output len_t    row_len_o,
  input  logic    be_idle_i,
  input  logic    row_done_i,
  // completion and status
  output logic    job_done_o,
  output logic    busy_o
);

  mid_state_e state_q;
  addr_t      src_q, dst_q;
  len_t       len_q;
  stride_t    src_stride_q, dst_stride_q;
  reps_t      reps_left_q;
  logic       job_done_q;
  logic       last_row;

  assign pop_o       = (state_q == MID_IDLE) && valid_i;
  assign row_start_o = (state_q == MID_ISSUE) && be_idle_i;
  assign last_row    = (reps_left_q == reps_t'(1));

  assign row_src_o  = src_q;
  assign row_dst_o  = dst_q;
  assign row_len_o  = len_q;
  assign job_done_o = job_done_q;
  assign busy_o     = (state_q != MID_IDLE);

  // ------------------------------------------------------------------------
  // row sequencing
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= MID_IDLE;
      reps_left_q <= '0;
      job_done_q  <= 1'b0;
    end else begin
      job_done_q <= 1'b0;
      case (state_q)
        MID_IDLE: begin
          if (pop_o) begin
            reps_left_q <= (job_reps_i == '0) ? reps_t'(1) : job_reps_i;
            state_q     <= MID_ISSUE;
          end
        end
        MID_ISSUE: begin
          if (row_start_o) begin
            state_q <= MID_WAIT;
          end
        end
        MID_WAIT: begin
          if (row_done_i) begin
            reps_left_q <= reps_left_q - reps_t'(1);
            if (last_row) begin
              job_done_q <= 1'b1;
              state_q    <= MID_IDLE;
            end else begin
              state_q <= MID_ISSUE;
            end
          end
        end
        default: state_q <= MID_IDLE;
      endcase
    end
  end

  // job fields, addresses step by their strides after each row
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      src_q        <= job_src_i;
      dst_q        <= job_dst_i;
      len_q        <= job_len_i;
      src_stride_q <= job_src_stride_i;
      dst_stride_q <= job_dst_stride_i;
    end else if ((state_q == MID_WAIT) && row_done_i) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

endmodule

// ==== dma_copy_backend.sv ====
// --------------------------------------------------------------------------
// copy backend: moves one row word by word over a single TCDM port
// each word is a read of the source followed by a write to the destination
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module dma_copy_backend
  import dma_xfer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // row request from the midend
  input  logic  row_start_i,
  input  addr_t row_src_i,
  input  addr_t row_dst_i,
  input  len_t  row_len_i,
  output logic  idle_o,
  output logic  row_done_o,
  // TCDM master port
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_we_o,
  output word_t mem_wdata_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  word_t mem_rdata_i
);

  localparam len_t WordBytes = len_t'(`DMA_DATA_W / 8);

  be_state_e state_q;
  addr_t     src_q, dst_q;
  len_t      rem_q;
  word_t     data_q;
  logic      row_done_q;
  logic      wr_gnt;

  assign idle_o     = (state_q == BE_IDLE);
  assign row_done_o = row_done_q;
  assign wr_gnt     = (state_q == BE_WRITE) && mem_gnt_i;

  // request fields only change after a grant
  assign mem_req_o   = (state_q == BE_READ) || (state_q == BE_WRITE);
  assign mem_we_o    = (state_q == BE_WRITE);
  assign mem_addr_o  = (state_q == BE_WRITE) ? dst_q : src_q;
  assign mem_wdata_o = data_q;

  // ------------------------------------------------------------------------
  // word FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= BE_IDLE;
      rem_q      <= '0;
      row_done_q <= 1'b0;
    end else begin
      row_done_q <= 1'b0;
      case (state_q)
        BE_IDLE: begin
          if (row_start_i) begin
            rem_q <= row_len_i;
            // empty row, nothing to move
            if (row_len_i == '0) begin
              row_done_q <= 1'b1;
            end else begin
              state_q <= BE_READ;
            end
          end
        end
        BE_READ: begin
          if (mem_gnt_i) begin
            state_q <= BE_RDATA;
          end
        end
        BE_RDATA: begin
          if (mem_rvalid_i) begin
            state_q <= BE_WRITE;
          end
        end
        BE_WRITE: begin
          if (mem_gnt_i) begin
            rem_q <= rem_q - WordBytes;
            if (rem_q <= WordBytes) begin
              row_done_q <= 1'b1;
              state_q    <= BE_IDLE;
            end else begin
              state_q <= BE_READ;
            end
          end
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

  // addresses and the word in flight
  always_ff @(posedge clk_i) begin
    if (idle_o && row_start_i) begin
      src_q <= row_src_i;
      dst_q <= row_dst_i;
    end else if (wr_gnt) begin
      src_q <= src_q + WordBytes;
      dst_q <= dst_q + WordBytes;
    end
    if ((state_q == BE_RDATA) && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

endmodule

// ==== dma_top.sv ====
// --------------------------------------------------------------------------
// single-stream TCDM DMA engine: frontend, job queue, 2D midend, backend
// program over the control port, watch term_event_o for completion
// --------------------------------------------------------------------------

`timescale 1ns/10ps

`include "dma_settings.svh"

module dma_top
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // control port
  input  logic      cfg_req_i,
  input  reg_addr_t cfg_addr_i,
  input  logic      cfg_we_i,
  input  reg_data_t cfg_wdata_i,
  output logic      cfg_gnt_o,
  output reg_data_t cfg_rdata_o,
  output logic      cfg_rvalid_o,
  // TCDM port
  output logic      mem_req_o,
  output addr_t     mem_addr_o,
  output logic      mem_we_o,
  output word_t     mem_wdata_o,
  input  logic      mem_gnt_i,
  input  logic      mem_rvalid_i,
  input  word_t     mem_rdata_i,
  // broadcast completion and status
  output logic      term_event_o,
  output logic      busy_o
);

  logic    push, full, q_valid, q_empty, pop;
  addr_t   fe_src, fe_dst, q_src, q_dst, row_src, row_dst;
  len_t    fe_len, q_len, row_len;
  stride_t fe_src_stride, fe_dst_stride, q_src_stride, q_dst_stride;
  reps_t   fe_reps, q_reps;
  logic    row_start, row_done, be_idle, job_done, mid_busy;

  assign busy_o       = !q_empty || mid_busy;
  assign term_event_o = job_done;

  // ------------------------------------------------------------------------
  // frontend
  // ------------------------------------------------------------------------
  dma_ctrl_regs i_dma_ctrl_regs (
    .clk_i,
    .rst_n_i,
    .cfg_req_i,
    .cfg_addr_i,
    .cfg_we_i,
    .cfg_wdata_i,
    .cfg_gnt_o,
    .cfg_rdata_o,
    .cfg_rvalid_o,
    .push_o          (push),
    .full_i          (full),
    .job_src_o       (fe_src),
    .job_dst_o       (fe_dst),
    .job_len_o       (fe_len),
    .job_src_stride_o(fe_src_stride),
    .job_dst_stride_o(fe_dst_stride),
    .job_reps_o      (fe_reps),
    .job_done_i      (job_done),
    .busy_i          (busy_o)
  );

  dma_req_fifo #(
    .Depth(`DMA_QUEUE_DEPTH)
  ) i_dma_req_fifo (
    .clk_i,
    .rst_n_i,
    .push_i      (push),
    .full_o      (full),
    .src_i       (fe_src),
    .dst_i       (fe_dst),
    .len_i       (fe_len),
    .src_stride_i(fe_src_stride),
    .dst_stride_i(fe_dst_stride),
    .reps_i      (fe_reps),
    .valid_o     (q_valid),
    .pop_i       (pop),
    .src_o       (q_src),
    .dst_o       (q_dst),
    .len_o       (q_len),
    .src_stride_o(q_src_stride),
    .dst_stride_o(q_dst_stride),
    .reps_o      (q_reps),
    .empty_o     (q_empty)
  );

  // ------------------------------------------------------------------------
  // midend and backend
  // ------------------------------------------------------------------------
  dma_2d_midend i_dma_2d_midend (
    .clk_i,
    .rst_n_i,
    .valid_i         (q_valid),
    .pop_o           (pop),
    .job_src_i       (q_src),
    .job_dst_i       (q_dst),
    .job_len_i       (q_len),
    .job_src_stride_i(q_src_stride),
    .job_dst_stride_i(q_dst_stride),
    .job_reps_i      (q_reps),
    .row_start_o     (row_start),
    .row_src_o       (row_src),
    .row_dst_o       (row_dst),
    .row_len_o       (row_len),
    .be_idle_i       (be_idle),
    .row_done_i      (row_done),
    .job_done_o      (job_done),
    .busy_o          (mid_busy)
  );

  dma_copy_backend i_dma_copy_backend (
    .clk_i,
    .rst_n_i,
    .row_start_i (row_start),
    .row_src_i   (row_src),
    .row_dst_i   (row_dst),
    .row_len_i   (row_len),
    .idle_o      (be_idle),
    .row_done_o  (row_done),
    .mem_req_o,
    .mem_addr_o,
    .mem_we_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i
  );

endmodule

// ==== dma_properties.sv ====
// --------------------------------------------------------------------------
// concurrent checks on the TCDM port, the control port and the event line
// bound into the DMA top level by the testbench
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module dma_properties (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        cfg_req_i,
  input logic        cfg_gnt_o,
  input logic        cfg_rvalid_o,
  input logic        mem_req_o,
  input logic [31:0] mem_addr_o,
  input logic        mem_we_o,
  input logic [31:0] mem_wdata_o,
  input logic        mem_gnt_i,
  input logic        term_event_o
);

  // count of failed assertions
  int unsigned fail_count = 0;

  // a waiting request keeps its fields until the grant
  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)
      && (!mem_we_o || $stable(mem_wdata_o)))
  else begin
    $error("memory request changed while waiting for its grant");
    fail_count++;
  end

  // completion event is a single cycle pulse
  term_event_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    term_event_o |=> !term_event_o)
  else begin
    $error("term_event_o high for more than one cycle");
    fail_count++;
  end

  cfg_response: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_req_i && cfg_gnt_o |=> cfg_rvalid_o)
  else begin
    $error("granted control access without read-valid");
    fail_count++;
  end

endmodule

// ==== tb_dma_top.sv ====
// --------------------------------------------------------------------------
// testbench for the DMA top level with a TCDM memory model and random grants
// applies the transfer table over the control port and checks memory and IDs
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_dma_top
  import dma_reg_pkg::*;
();

  localparam int NUM_XFERS = 6;

  logic        clk_i, rst_n_i;
  logic        cfg_req_i, cfg_we_i, cfg_gnt_o, cfg_rvalid_o;
  reg_addr_t   cfg_addr_i;
  reg_data_t   cfg_wdata_i, cfg_rdata_o;
  logic        mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
  logic        term_event_o, busy_o;

  logic [31:0] mem [256];
  logic [31:0] exp_mem [256];
  integer      seed = 32'h49926c4a;
  int unsigned errors = 0;
  int unsigned events = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  // ------------------------------------------------------------------------
  // transfer table with src, dst, len, src stride, dst stride and reps
  // ------------------------------------------------------------------------
  // entries 0..2 run one at a time and 3..5 are queued back to back
  logic [31:0] tbl_src  [NUM_XFERS] = '{32'h000, 32'h040, 32'h100, 32'h000, 32'h080, 32'h100};
  logic [31:0] tbl_dst  [NUM_XFERS] = '{32'h200, 32'h280, 32'h300, 32'h200, 32'h300, 32'h380};
  logic [31:0] tbl_len  [NUM_XFERS] = '{32'h010, 32'h008, 32'h00c, 32'h010, 32'h010, 32'h008};
  logic [31:0] tbl_sstr [NUM_XFERS] = '{32'h000, 32'h020, 32'h010, 32'h010, 32'h020, 32'h008};
  logic [31:0] tbl_dstr [NUM_XFERS] = '{32'h000, 32'h010, 32'h020, 32'h010, 32'h010, 32'h010};
  logic [31:0] tbl_reps [NUM_XFERS] = '{32'd1, 32'd3, 32'd0, 32'd4, 32'd4, 32'd3};

  dma_top dma_top_i (.*);

  bind dma_top dma_properties i_dma_properties (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_gnt_o   (cfg_gnt_o),
    .cfg_rvalid_o(cfg_rvalid_o),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_we_o    (mem_we_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_gnt_i   (mem_gnt_i),
    .term_event_o(term_event_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : watchdog
    repeat (NUM_XFERS * 2000) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", NUM_XFERS * 2000);
    $display("Done: errors found");
    $finish;
  end

  // TCDM model that grants three cycles in four
  // read data returns one cycle after the grant
  initial begin : mem_model
    logic        acc;
    logic        acc_we;
    logic [7:0]  acc_idx;
    logic [31:0] acc_wdata;
    forever begin
      @(negedge clk_i);
      acc       = mem_req_o && mem_gnt_i && rst_n_i;
      acc_we    = mem_we_o;
      acc_idx   = mem_addr_o[9:2];
      acc_wdata = mem_wdata_o;
      @(posedge clk_i);
      #1;
      if (acc && acc_we) begin
        mem[acc_idx] = acc_wdata;
      end
      mem_rvalid_i = acc && !acc_we;
      mem_rdata_i  = (acc && !acc_we) ? mem[acc_idx] : 32'h0;
      mem_gnt_i    = (($random(seed) & 3) != 0);
    end
  end

  initial begin : event_counter
    forever begin
      @(negedge clk_i);
      if (rst_n_i && term_event_o) begin
        events++;
      end
    end
  end

  function automatic logic [31:0] fill_word(input int n);
    return 32'hc0de0000 ^ (32'(n) * 32'h00010003);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // control port accesses
  // ------------------------------------------------------------------------
  task automatic cfg_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata);
    logic granted;
    granted = 1'b0;
    @(posedge clk_i);
    #1;
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    while (!granted) begin
      @(negedge clk_i);
      granted = cfg_gnt_o;
      @(posedge clk_i);
      #1;
    end
    cfg_req_i = 1'b0;
    cfg_we_i  = 1'b0;
    @(negedge clk_i);
    if (!cfg_rvalid_o) begin
      $display("no read-valid after a granted control access at offset %h", addr);
      errors++;
    end
    rdata = cfg_rdata_o;
  endtask

  // a write answers with zero data
  task automatic cfg_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t rdata;
    cfg_access(1'b1, addr, data, rdata);
    check_value("cfg_rdata_o", rdata, 32'h0);
  endtask

  task automatic cfg_read(input reg_addr_t addr, output reg_data_t data);
    cfg_access(1'b0, addr, 32'h0, data);
  endtask

  // program one table entry and launch it
  task automatic launch_xfer(input int idx, input logic [31:0] exp_id);
    reg_data_t id;
    cfg_write(REG_SRC, tbl_src[idx]);
    cfg_write(REG_DST, tbl_dst[idx]);
    cfg_write(REG_LEN, tbl_len[idx]);
    cfg_write(REG_SRC_STRIDE, tbl_sstr[idx]);
    cfg_write(REG_DST_STRIDE, tbl_dstr[idx]);
    cfg_write(REG_REPS, tbl_reps[idx]);
    cfg_read(REG_NEXT_ID, id);
    check_value("REG_NEXT_ID", id, exp_id);
  endtask

  // ------------------------------------------------------------------------
  // reference memory
  // ------------------------------------------------------------------------
  task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
  endtask

  // row r moves len bytes from src + r * src stride to dst + r * dst stride
  task automatic copy_expected(input int idx);
    int          rows;
    logic [31:0] s_addr, d_addr;
    rows = (tbl_reps[idx] == 32'd0) ? 1 : int'(tbl_reps[idx]);
    for (int r = 0; r < rows; r++) begin
      for (int w = 0; w < int'(tbl_len[idx] / 4); w++) begin
        s_addr = tbl_src[idx] + 32'(r) * tbl_sstr[idx] + 32'(w * 4);
        d_addr = tbl_dst[idx] + 32'(r) * tbl_dstr[idx] + 32'(w * 4);
        exp_mem[d_addr[9:2]] = exp_mem[s_addr[9:2]];
      end
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < 256; i++) begin
      check_value($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
    end
  endtask

  task automatic wait_events(input int unsigned target);
    while (events < target) begin
      @(negedge clk_i);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin : main
    int unsigned errs_before;
    int unsigned base;
    logic [31:0] next_id;
    reg_data_t   rd;
    rst_n_i      = 1'b0;
    cfg_req_i    = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    next_id      = 32'd1;
    fill_memory();
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    errs_before = errors;
    @(negedge clk_i);
    check_value("cfg_gnt_o", 32'(cfg_gnt_o), 32'h1);
    check_value("cfg_rvalid_o", 32'(cfg_rvalid_o), 32'h0);
    check_value("mem_req_o", 32'(mem_req_o), 32'h0);
    check_value("term_event_o", 32'(term_event_o), 32'h0);
    check_value("busy_o", 32'(busy_o), 32'h0);
    cfg_read(REG_DONE_ID, rd);
    check_value("REG_DONE_ID", rd, 32'h0);
    cfg_read(REG_STATUS, rd);
    check_value("REG_STATUS", rd, 32'h0);
    finish_test("reset_state", errs_before);

    // single and 2D transfers run one at a time
    for (int i = 0; i < 3; i++) begin
      errs_before = errors;
      fill_memory();
      copy_expected(i);
      base = events;
      launch_xfer(i, next_id);
      next_id++;
      wait_events(base + 1);
      compare_memory();
      cfg_read(REG_DONE_ID, rd);
      check_value("REG_DONE_ID", rd, next_id - 32'd1);
      check_value("term_event_o count", 32'(events), next_id - 32'd1);
      check_value("busy_o", 32'(busy_o), 32'h0);
      finish_test($sformatf("xfer_%0d", i), errs_before);
    end

    // three launches queued behind each other
    errs_before = errors;
    fill_memory();
    base = events;
    for (int i = 3; i < NUM_XFERS; i++) begin
      copy_expected(i);
      launch_xfer(i, next_id);
      next_id++;
    end
    wait_events(base + 1);
    check_value("busy_o", 32'(busy_o), 32'h1);
    wait_events(base + 2);
    check_value("busy_o", 32'(busy_o), 32'h1);
    wait_events(base + 3);
    check_value("busy_o", 32'(busy_o), 32'h0);
    compare_memory();
    cfg_read(REG_DONE_ID, rd);
    check_value("REG_DONE_ID", rd, next_id - 32'd1);
    check_value("term_event_o count", 32'(events), next_id - 32'd1);
    cfg_read(REG_STATUS, rd);
    check_value("REG_STATUS", rd, 32'h0);
    finish_test("queueing", errs_before);

    errors += dma_top_i.i_dma_properties.fail_count;
    $display("tests %0d, failed %0d, errors %0d, events %0d",
             tests_run, tests_failed, errors, events);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
dma_reg_pkg.sv
dma_xfer_pkg.sv
dma_ctrl_regs.sv
dma_req_fifo.sv
dma_2d_midend.sv
dma_copy_backend.sv
dma_top.sv
dma_properties.sv
tb_dma_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_dma_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
